// ==== build.f ====
common/video_mem_pkg.sv
common/video_scan_pkg.sv
video_memory/sram_macro_pair.sv
video_memory/video_memory.sv
hdl/host_bridge.sv
hdl/scanline_reader.sv
hdl/video_subsystem.sv
verif/tb_clock.sv
verif/video_subsystem_tb.sv

// ==== common/video_mem_pkg.sv ====
package video_mem_pkg;

	// Data word and byte lanes
	localparam int WORD_WIDTH = 32;
	localparam int WORD_BYTES = WORD_WIDTH / 8;

	// One SRAM bank holds 512 words
	localparam int SRAM_ADDRESS_SIZE = 9;
	localparam int SRAM_DEPTH = 1 << SRAM_ADDRESS_SIZE;

	localparam int BANK_COUNT = 4;
	localparam int BANK_BITS = $clog2(BANK_COUNT);

	// Byte address layout: bank in 12:11, word index in 10:2
	localparam int WORD_INDEX_LSB = 2;
	localparam int BANK_LSB = WORD_INDEX_LSB + SRAM_ADDRESS_SIZE;
	localparam int VIDEO_ADDRESS_SIZE = BANK_LSB + BANK_BITS;

	localparam int BUS_ADDRESS_SIZE = 24;

	typedef logic [WORD_WIDTH-1:0] word_t;
	typedef logic [WORD_BYTES-1:0] byte_mask_t;
	typedef logic [SRAM_ADDRESS_SIZE-1:0] sram_addr_t;
	typedef logic [BANK_BITS-1:0] bank_t;
	typedef logic [VIDEO_ADDRESS_SIZE-1:0] video_addr_t;
	typedef logic [BUS_ADDRESS_SIZE-1:0] bus_addr_t;

endpackage

// ==== common/video_scan_pkg.sv ====
package video_scan_pkg;

	// Frame geometry in 32-bit words
	localparam int LINE_WORDS = 64;
	localparam int FRAME_LINES = 32;
	localparam int FRAME_WORDS = LINE_WORDS * FRAME_LINES;

	localparam int COLUMN_BITS = $clog2(LINE_WORDS);
	localparam int LINE_BITS = $clog2(FRAME_LINES);
	localparam int FRAME_WORD_BITS = $clog2(FRAME_WORDS);

	typedef enum logic [2:0] {
		BRIDGE_IDLE,
		BRIDGE_BUS,
		BRIDGE_CAPTURE,
		BRIDGE_ACK,
		BRIDGE_RELEASE
	} bridge_state_t;

	typedef enum logic [2:0] {
		SCAN_IDLE,
		SCAN_FETCH,
		SCAN_DATA,
		SCAN_REQUEST,
		SCAN_RELEASE
	} scan_state_t;

endpackage

// ==== hdl/host_bridge.sv ====
`timescale 1ns/1ns

module host_bridge import video_mem_pkg::*, video_scan_pkg::*; (
	input logic clk,
	input logic reset,

	// Host side, four-phase req/ack
	input logic host_req,
	input logic host_write,
	input bus_addr_t host_address,
	input byte_mask_t host_byte_enable,
	input word_t host_wdata,
	output logic host_ack,
	output word_t host_rdata,

	// Peripheral bus side
	output logic bus_we,
	output logic bus_oe,
	output bus_addr_t bus_address,
	output byte_mask_t bus_byte_select,
	output word_t bus_write_data,
	input word_t bus_read_data
);

	bridge_state_t state;
	logic write_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= BRIDGE_IDLE;
			host_ack <= 1'b0;
		end else begin
			case (state)
				BRIDGE_IDLE: begin
					if (host_req) begin
						state <= BRIDGE_BUS;
					end
				end
				// Reads take one more cycle for the data to come back
				BRIDGE_BUS: begin
					state <= write_q ? BRIDGE_ACK : BRIDGE_CAPTURE;
				end
				BRIDGE_CAPTURE: begin
					state <= BRIDGE_ACK;
				end
				BRIDGE_ACK: begin
					host_ack <= 1'b1;
					state <= BRIDGE_RELEASE;
				end
				BRIDGE_RELEASE: begin
					if (!host_req) begin
						host_ack <= 1'b0;
						state <= BRIDGE_IDLE;
					end
				end
				default: begin
					state <= BRIDGE_IDLE;
				end
			endcase
		end
	end

	// Latch the transaction when req is first seen
	always_ff @(posedge clk) begin
		if (state == BRIDGE_IDLE && host_req) begin
			write_q <= host_write;
			bus_address <= host_address;
			bus_byte_select <= host_byte_enable;
			bus_write_data <= host_wdata;
		end
		if (state == BRIDGE_CAPTURE) begin
			host_rdata <= bus_read_data;
		end
	end

	// Single-cycle strobes
	assign bus_we = (state == BRIDGE_BUS) && write_q;
	assign bus_oe = (state == BRIDGE_BUS) && !write_q;

endmodule

// ==== hdl/scanline_reader.sv ====
`timescale 1ns/1ns

module scanline_reader import video_mem_pkg::*, video_scan_pkg::*; (
	input logic clk,
	input logic reset,
	input logic frame_enable,

	// Video port of the memory
	output video_addr_t video_address,
	input word_t video_data,

	// Pixel sink, four-phase req/ack
	output logic pixel_req,
	input logic pixel_ack,
	output word_t pixel_data,
	output logic pixel_sof,
	output logic pixel_eol
);

	scan_state_t state;
	logic [COLUMN_BITS-1:0] column;
	logic [LINE_BITS-1:0] line;
	logic [FRAME_WORD_BITS-1:0] frame_word;
	logic last_column;
	logic last_word;

	assign frame_word = {line, column};
	assign last_column = column == COLUMN_BITS'(LINE_WORDS - 1);
	assign last_word = frame_word == FRAME_WORD_BITS'(FRAME_WORDS - 1);

	// Word-aligned byte address of the current word
	assign video_address = {frame_word, 2'b00};

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= SCAN_IDLE;
			column <= '0;
			line <= '0;
			pixel_req <= 1'b0;
		end else begin
			case (state)
				SCAN_IDLE: begin
					if (frame_enable) begin
						state <= SCAN_FETCH;
					end
				end
				SCAN_FETCH: begin
					state <= SCAN_DATA;
				end
				SCAN_DATA: begin
					pixel_req <= 1'b1;
					state <= SCAN_REQUEST;
				end
				SCAN_REQUEST: begin
					if (pixel_ack) begin
						pixel_req <= 1'b0;
						state <= SCAN_RELEASE;
					end
				end
				// Advance once the sink has dropped ack
				SCAN_RELEASE: begin
					if (!pixel_ack) begin
						if (last_column) begin
							column <= '0;
							line <= last_word ? '0 : line + 1'b1;
						end else begin
							column <= column + 1'b1;
						end
						if (last_word && !frame_enable) begin
							state <= SCAN_IDLE;
						end else begin
							state <= SCAN_FETCH;
						end
					end
				end
				default: begin
					state <= SCAN_IDLE;
				end
			endcase
		end
	end

	// Word and flags are held while req is up
	always_ff @(posedge clk) begin
		if (state == SCAN_DATA) begin
			pixel_data <= video_data;
			pixel_sof <= frame_word == '0;
			pixel_eol <= last_column;
		end
	end

endmodule

// ==== hdl/video_subsystem.sv ====
`timescale 1ns/1ns

module video_subsystem import video_mem_pkg::*; (
	input logic clk,
	input logic reset,
	input logic frame_enable,

	input logic host_req,
	input logic host_write,
	input bus_addr_t host_address,
	input byte_mask_t host_byte_enable,
	input word_t host_wdata,
	output logic host_ack,
	output word_t host_rdata,

	output logic pixel_req,
	input logic pixel_ack,
	output word_t pixel_data,
	output logic pixel_sof,
	output logic pixel_eol
);

	logic bus_we;
	logic bus_oe;
	bus_addr_t bus_address;
	byte_mask_t bus_byte_select;
	word_t bus_write_data;
	word_t bus_read_data;
	video_addr_t video_address;
	word_t video_data;

	// SRAM pair nets, index 0 is the left pair
	logic sram_clk0 [2];
	logic [1:0] sram_csb0 [2];
	logic sram_web0 [2];
	byte_mask_t sram_wmask0 [2];
	sram_addr_t sram_addr0 [2];
	word_t sram_din0 [2];
	logic [2*WORD_WIDTH-1:0] sram_dout0 [2];
	logic sram_clk1 [2];
	logic [1:0] sram_csb1 [2];
	sram_addr_t sram_addr1 [2];
	logic [2*WORD_WIDTH-1:0] sram_dout1 [2];

	host_bridge u_host_bridge (
		.clk(clk),
		.reset(reset),
		.host_req(host_req),
		.host_write(host_write),
		.host_address(host_address),
		.host_byte_enable(host_byte_enable),
		.host_wdata(host_wdata),
		.host_ack(host_ack),
		.host_rdata(host_rdata),
		.bus_we(bus_we),
		.bus_oe(bus_oe),
		.bus_address(bus_address),
		.bus_byte_select(bus_byte_select),
		.bus_write_data(bus_write_data),
		.bus_read_data(bus_read_data)
	);

	video_memory u_video_memory (
		.clk(clk),
		.reset(reset),
		.bus_we(bus_we),
		.bus_oe(bus_oe),
		.bus_address(bus_address),
		.bus_byte_select(bus_byte_select),
		.bus_write_data(bus_write_data),
		.bus_read_data(bus_read_data),
		.video_address(video_address),
		.video_data(video_data),
		.sram0_clk0(sram_clk0[0]),
		.sram0_csb0(sram_csb0[0]),
		.sram0_web0(sram_web0[0]),
		.sram0_wmask0(sram_wmask0[0]),
		.sram0_addr0(sram_addr0[0]),
		.sram0_din0(sram_din0[0]),
		.sram0_dout0(sram_dout0[0]),
		.sram0_clk1(sram_clk1[0]),
		.sram0_csb1(sram_csb1[0]),
		.sram0_addr1(sram_addr1[0]),
		.sram0_dout1(sram_dout1[0]),
		.sram1_clk0(sram_clk0[1]),
		.sram1_csb0(sram_csb0[1]),
		.sram1_web0(sram_web0[1]),
		.sram1_wmask0(sram_wmask0[1]),
		.sram1_addr0(sram_addr0[1]),
		.sram1_din0(sram_din0[1]),
		.sram1_dout0(sram_dout0[1]),
		.sram1_clk1(sram_clk1[1]),
		.sram1_csb1(sram_csb1[1]),
		.sram1_addr1(sram_addr1[1]),
		.sram1_dout1(sram_dout1[1])
	);

	sram_macro_pair u_sram_left (
		.clk0(sram_clk0[0]),
		.csb0(sram_csb0[0]),
		.web0(sram_web0[0]),
		.wmask0(sram_wmask0[0]),
		.addr0(sram_addr0[0]),
		.din0(sram_din0[0]),
		.dout0(sram_dout0[0]),
		.clk1(sram_clk1[0]),
		.csb1(sram_csb1[0]),
		.addr1(sram_addr1[0]),
		.dout1(sram_dout1[0])
	);

	sram_macro_pair u_sram_right (
		.clk0(sram_clk0[1]),
		.csb0(sram_csb0[1]),
		.web0(sram_web0[1]),
		.wmask0(sram_wmask0[1]),
		.addr0(sram_addr0[1]),
		.din0(sram_din0[1]),
		.dout0(sram_dout0[1]),
		.clk1(sram_clk1[1]),
		.csb1(sram_csb1[1]),
		.addr1(sram_addr1[1]),
		.dout1(sram_dout1[1])
	);

	scanline_reader u_scanline_reader (
		.clk(clk),
		.reset(reset),
		.frame_enable(frame_enable),
		.video_address(video_address),
		.video_data(video_data),
		.pixel_req(pixel_req),
		.pixel_ack(pixel_ack),
		.pixel_data(pixel_data),
		.pixel_sof(pixel_sof),
		.pixel_eol(pixel_eol)
	);

endmodule

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator and run the video subsystem testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f build.f \
	--top-module video_subsystem_tb -o video_subsystem_sim

# The simulator exits non-zero on failure; the log decides the result
./obj_dir/video_subsystem_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
	echo "Simulation passed"
	exit 0
fi

echo "Simulation failed"
exit 1

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
	output logic clk
);

	// 100 ns period
	localparam int HALF_PERIOD = 50;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

endmodule

// ==== verif/video_subsystem_tb.sv ====
`timescale 1ns/1ns

module video_subsystem_tb import video_mem_pkg::*, video_scan_pkg::*; ();

	localparam logic [31:0] SEED = 32'd39528;
	localparam int RANDOM_OPS = 200;
	// Worst case about 10 cycles per host transfer and 9 per pixel word
	localparam int CYCLE_LIMIT = 80000;

	logic clk;
	logic reset;
	logic frame_enable;
	logic host_req;
	logic host_write;
	bus_addr_t host_address;
	byte_mask_t host_byte_enable;
	word_t host_wdata;
	logic host_ack;
	word_t host_rdata;
	logic pixel_req;
	logic pixel_ack;
	word_t pixel_data;
	logic pixel_sof;
	logic pixel_eol;

	word_t model [FRAME_WORDS];
	logic [31:0] host_rand;
	logic [31:0] sink_rand;
	logic second_frame = 1'b0;
	logic frames_done = 1'b0;
	int cycle_count = 0;

	tb_clock u_tb_clock (
		.clk(clk)
	);

	video_subsystem u_video_subsystem (
		.clk(clk),
		.reset(reset),
		.frame_enable(frame_enable),
		.host_req(host_req),
		.host_write(host_write),
		.host_address(host_address),
		.host_byte_enable(host_byte_enable),
		.host_wdata(host_wdata),
		.host_ack(host_ack),
		.host_rdata(host_rdata),
		.pixel_req(pixel_req),
		.pixel_ack(pixel_ack),
		.pixel_data(pixel_data),
		.pixel_sof(pixel_sof),
		.pixel_eol(pixel_eol)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Host and sink draw from separate streams
	function automatic logic [31:0] host_random();
		host_rand = xorshift(host_rand);
		return host_rand;
	endfunction

	function automatic logic [31:0] stall_random();
		sink_rand = xorshift(sink_rand);
		return sink_rand;
	endfunction

	// Only the enabled byte lanes take the new data
	function automatic word_t merge_bytes(input word_t old, input word_t data,
			input byte_mask_t mask);
		word_t result;
		result = old;
		for (int b = 0; b < 4; b++) begin
			if (mask[b]) begin
				result[b*8 +: 8] = data[b*8 +: 8];
			end
		end
		return result;
	endfunction

	task automatic report_error(input string message);
		$display("error: time %0t: %s", $time, message);
		$display("TEST RESULT: FAIL");
		$fatal(1, "check failed");
	endtask

	task automatic check_word(input string what, input word_t actual, input word_t expected);
		assert (actual == expected)
		else report_error($sformatf("%s is 0x%08h, expected 0x%08h", what, actual, expected));
	endtask

	// One four-phase host transaction with ack latency and release checks
	task automatic host_transfer(input logic write, input int index, input byte_mask_t mask,
			input word_t wdata, input int hold, output word_t rdata);
		int cycles;
		int expected_cycles;
		expected_cycles = write ? 3 : 4;
		@(negedge clk);
		assert (!host_ack) else report_error("host_ack high before req was raised");
		@(posedge clk);
		host_req <= 1'b1;
		host_write <= write;
		host_address <= bus_addr_t'(index << 2);
		host_byte_enable <= mask;
		host_wdata <= wdata;
		cycles = 0;
		@(negedge clk);
		while (!host_ack) begin
			cycles++;
			@(negedge clk);
		end
		assert (cycles == expected_cycles)
		else report_error($sformatf("host_ack after %0d cycles, expected %0d",
			cycles, expected_cycles));
		rdata = host_rdata;
		repeat (hold) @(posedge clk);
		@(posedge clk);
		host_req <= 1'b0;
		@(negedge clk);
		@(negedge clk);
		assert (!host_ack) else report_error("host_ack still high one cycle after req fell");
	endtask

	task automatic sink_word(input int index, input logic last);
		int stall;
		@(negedge clk);
		while (!pixel_req) begin
			@(negedge clk);
		end
		check_word($sformatf("pixel %0d", index), pixel_data, model[index]);
		assert (pixel_sof == (index == 0) && pixel_eol == (index % LINE_WORDS == LINE_WORDS - 1))
		else report_error($sformatf("pixel %0d has sof %b eol %b", index, pixel_sof, pixel_eol));
		stall = int'(stall_random() % 4);
		repeat (stall) @(posedge clk);
		@(posedge clk);
		pixel_ack <= 1'b1;
		// Stop after this word so no third frame starts
		if (last) begin
			frame_enable <= 1'b0;
		end
		@(negedge clk);
		while (pixel_req) begin
			@(negedge clk);
		end
		@(posedge clk);
		pixel_ack <= 1'b0;
	endtask

	task automatic sink_frames();
		for (int n = 0; n < 2 * FRAME_WORDS; n++) begin
			if (n == FRAME_WORDS) begin
				second_frame = 1'b1;
			end
			sink_word(n % FRAME_WORDS, n == 2 * FRAME_WORDS - 1);
		end
		frames_done = 1'b1;
	endtask

	// Bus port reads while the video port is busy
	task automatic frame_host_reads();
		word_t rdata;
		int index;
		int hold;
		wait (second_frame);
		while (!frames_done) begin
			index = int'(host_random() % FRAME_WORDS);
			hold = int'(host_random() % 4);
			host_transfer(1'b0, index, '1, '0, hold, rdata);
			check_word($sformatf("word %0d during frame", index), rdata, model[index]);
		end
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == CYCLE_LIMIT) begin
			$display("Simulation timed out after %0d clock cycles", cycle_count);
			$display("TEST RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	initial begin
		word_t rdata;
		word_t data;
		byte_mask_t mask;
		logic [31:0] choice;
		int index;
		int hold;
		int pending [$];
		host_rand = SEED;
		sink_rand = SEED ^ 32'h2545f491;
		reset = 1'b1;
		frame_enable = 1'b0;
		host_req = 1'b0;
		host_write = 1'b0;
		host_address = '0;
		host_byte_enable = '0;
		host_wdata = '0;
		pixel_ack = 1'b0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		assert (!host_ack && !pixel_req) else report_error("handshake outputs active after reset");

		// Fill every word, then spot-check all four banks
		for (int i = 0; i < FRAME_WORDS; i++) begin
			data = host_random();
			host_transfer(1'b1, i, '1, data, 0, rdata);
			model[i] = data;
		end
		for (int n = 0; n < RANDOM_OPS; n++) begin
			index = int'(host_random() % FRAME_WORDS);
			host_transfer(1'b0, index, '1, '0, 0, rdata);
			check_word($sformatf("word %0d", index), rdata, model[index]);
		end

		for (int n = 0; n < RANDOM_OPS; n++) begin
			index = int'(host_random() % FRAME_WORDS);
			mask = byte_mask_t'(host_random());
			data = host_random();
			host_transfer(1'b1, index, mask, data, 0, rdata);
			model[index] = merge_bytes(model[index], data, mask);
			pending.push_back(index);
		end
		foreach (pending[k]) begin
			host_transfer(1'b0, pending[k], '1, '0, 0, rdata);
			check_word($sformatf("masked word %0d", pending[k]), rdata, model[pending[k]]);
		end

		for (int n = 0; n < RANDOM_OPS; n++) begin
			index = int'(host_random() % FRAME_WORDS);
			hold = int'(host_random() % 4);
			choice = host_random();
			if (choice[0]) begin
				mask = byte_mask_t'(host_random());
				data = host_random();
				host_transfer(1'b1, index, mask, data, hold, rdata);
				model[index] = merge_bytes(model[index], data, mask);
			end else begin
				host_transfer(1'b0, index, '1, '0, hold, rdata);
				check_word($sformatf("mixed word %0d", index), rdata, model[index]);
			end
		end

		@(posedge clk);
		frame_enable <= 1'b1;
		fork
			sink_frames();
			frame_host_reads();
		join
		repeat (10) begin
			@(negedge clk);
			assert (!pixel_req) else report_error("reader kept running after the second frame");
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== video_memory/sram_macro_pair.sv ====
`timescale 1ns/1ns

module sram_macro_pair import video_mem_pkg::*; (
	// Read/write port
	input logic clk0,
	input logic [1:0] csb0,
	input logic web0,
	input byte_mask_t wmask0,
	input sram_addr_t addr0,
	input word_t din0,
	output logic [2*WORD_WIDTH-1:0] dout0,

	// Read-only port
	input logic clk1,
	input logic [1:0] csb1,
	input sram_addr_t addr1,
	output logic [2*WORD_WIDTH-1:0] dout1
);

	word_t rdata0 [2];
	word_t rdata1 [2];

	// Low half is macro 0, high half macro 1
	for (genvar h = 0; h < 2; h++) begin : g_half
		word_t mem [SRAM_DEPTH];

		always_ff @(posedge clk0) begin
			if (!csb0[h]) begin
				if (!web0) begin
					for (int b = 0; b < WORD_BYTES; b++) begin
						if (wmask0[b]) begin
							mem[addr0][b*8 +: 8] <= din0[b*8 +: 8];
						end
					end
				end else begin
					rdata0[h] <= mem[addr0];
				end
			end
		end

		// Output holds while deselected
		always_ff @(posedge clk1) begin
			if (!csb1[h]) begin
				rdata1[h] <= mem[addr1];
			end
		end
	end

	assign dout0 = {rdata0[1], rdata0[0]};
	assign dout1 = {rdata1[1], rdata1[0]};

endmodule

// ==== video_memory/video_memory.sv ====
`timescale 1ns/1ns

module video_memory import video_mem_pkg::*; (
	input logic clk,
	input logic reset,

	// Peripheral bus
	input logic bus_we,
	input logic bus_oe,
	input bus_addr_t bus_address,
	input byte_mask_t bus_byte_select,
	input word_t bus_write_data,
	output word_t bus_read_data,

	// Video port
	input video_addr_t video_address,
	output word_t video_data,

	// Left pair, read/write port
	output logic sram0_clk0,
	output logic [1:0] sram0_csb0,
	output logic sram0_web0,
	output byte_mask_t sram0_wmask0,
	output sram_addr_t sram0_addr0,
	output word_t sram0_din0,
	input logic [2*WORD_WIDTH-1:0] sram0_dout0,

	// Left pair, read port
	output logic sram0_clk1,
	output logic [1:0] sram0_csb1,
	output sram_addr_t sram0_addr1,
	input logic [2*WORD_WIDTH-1:0] sram0_dout1,

	// Right pair, read/write port
	output logic sram1_clk0,
	output logic [1:0] sram1_csb0,
	output logic sram1_web0,
	output byte_mask_t sram1_wmask0,
	output sram_addr_t sram1_addr0,
	output word_t sram1_din0,
	input logic [2*WORD_WIDTH-1:0] sram1_dout0,

	// Right pair, read port
	output logic sram1_clk1,
	output logic [1:0] sram1_csb1,
	output sram_addr_t sram1_addr1,
	input logic [2*WORD_WIDTH-1:0] sram1_dout1
);

	logic [BANK_COUNT-1:0] bus_csb;
	logic [BANK_COUNT-1:0] video_csb;
	logic [BANK_COUNT*WORD_WIDTH-1:0] bus_dout;
	logic [BANK_COUNT*WORD_WIDTH-1:0] video_dout;
	bank_t bus_bank;
	bank_t video_bank;
	bank_t bus_bank_q;
	bank_t video_bank_q;
	sram_addr_t bus_index;
	sram_addr_t video_index;
	logic bus_read_q;

	assign bus_bank = bus_address[BANK_LSB +: BANK_BITS];
	assign bus_index = bus_address[WORD_INDEX_LSB +: SRAM_ADDRESS_SIZE];
	assign video_bank = video_address[BANK_LSB +: BANK_BITS];
	assign video_index = video_address[WORD_INDEX_LSB +: SRAM_ADDRESS_SIZE];

	// Active-low one-hot selects, bus port only during a bus cycle
	always_comb begin
		bus_csb = '1;
		if (bus_we || bus_oe) begin
			bus_csb[bus_bank] = 1'b0;
		end
	end

	always_comb begin
		video_csb = '1;
		video_csb[video_bank] = 1'b0;
	end

	// Banks 0 and 1 live in the left pair, 2 and 3 in the right
	assign sram0_clk0 = clk;
	assign sram0_csb0 = bus_csb[1:0];
	assign sram0_web0 = !bus_we;
	assign sram0_wmask0 = bus_byte_select;
	assign sram0_addr0 = bus_index;
	assign sram0_din0 = bus_write_data;
	assign sram0_clk1 = clk;
	assign sram0_csb1 = video_csb[1:0];
	assign sram0_addr1 = video_index;

	assign sram1_clk0 = clk;
	assign sram1_csb0 = bus_csb[3:2];
	assign sram1_web0 = !bus_we;
	assign sram1_wmask0 = bus_byte_select;
	assign sram1_addr0 = bus_index;
	assign sram1_din0 = bus_write_data;
	assign sram1_clk1 = clk;
	assign sram1_csb1 = video_csb[3:2];
	assign sram1_addr1 = video_index;

	assign bus_dout = {sram1_dout0, sram0_dout0};
	assign video_dout = {sram1_dout1, sram0_dout1};

	// SRAM output lags the address by one cycle, so the mux uses the bank from then
	always_ff @(posedge clk) begin
		if (reset) begin
			bus_read_q <= 1'b0;
		end else begin
			bus_read_q <= bus_oe;
		end
	end

	always_ff @(posedge clk) begin
		bus_bank_q <= bus_bank;
		video_bank_q <= video_bank;
	end

	assign bus_read_data = bus_read_q ? bus_dout[bus_bank_q*WORD_WIDTH +: WORD_WIDTH] : '0;
	assign video_data = video_dout[video_bank_q*WORD_WIDTH +: WORD_WIDTH];

endmodule
